// File: common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    localparam int LCD_DATA_W = 8;
    localparam int COL_W      = 5;  // Up to 32 characters per line

    // Sequencer states
    typedef enum logic [3:0] {
        ST_POWER_WAIT   = 4'd0,
        ST_FUNCTION_SET = 4'd1,
        ST_ENTRY_MODE   = 4'd2,
        ST_DISPLAY_ON   = 4'd3,
        ST_LINE1        = 4'd4,
        ST_LINE2        = 4'd5,
        ST_RETURN_HOME  = 4'd6,
        ST_CLEAR        = 4'd7,
        ST_REFRESH_WAIT = 4'd8
    } lcd_state_e;

    // Code 3 is shown as a blank display
    typedef enum logic [1:0] {
        WIN_NONE = 2'd0,
        WIN_P1   = 2'd1,
        WIN_P2   = 2'd2
    } winner_e;

    localparam logic [LCD_DATA_W-1:0] CMD_FUNCTION_SET = 8'h3C;  // 8 bit, 2 lines
    localparam logic [LCD_DATA_W-1:0] CMD_ENTRY_MODE   = 8'h06;
    localparam logic [LCD_DATA_W-1:0] CMD_DISPLAY_ON   = 8'h0C;
    localparam logic [LCD_DATA_W-1:0] CMD_LINE1_ADDR   = 8'h80;
    localparam logic [LCD_DATA_W-1:0] CMD_LINE2_ADDR   = 8'hC0;
    localparam logic [LCD_DATA_W-1:0] CMD_RETURN_HOME  = 8'h02;
    localparam logic [LCD_DATA_W-1:0] CMD_CLEAR        = 8'h01;

    localparam logic [LCD_DATA_W-1:0] CHAR_SPACE = 8'h20;
    localparam logic [LCD_DATA_W-1:0] CHAR_HEART = 8'h9D;  // Controller ROM glyph
    localparam logic [LCD_DATA_W-1:0] CHAR_P     = 8'h50;
    localparam logic [LCD_DATA_W-1:0] CHAR_ONE   = 8'h31;
    localparam logic [LCD_DATA_W-1:0] CHAR_TWO   = 8'h32;
    localparam logic [LCD_DATA_W-1:0] CHAR_W     = 8'h57;
    localparam logic [LCD_DATA_W-1:0] CHAR_I     = 8'h69;
    localparam logic [LCD_DATA_W-1:0] CHAR_N     = 8'h6E;

endpackage

`default_nettype wire

// File: lcd/lcd_message_rom.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_message_rom #(
    parameter int LINE_CHARS = 16
) (
    input  var lcd_pkg::winner_e              winner,
    input  wire logic                         line_sel,
    input  wire logic [lcd_pkg::COL_W-1:0]    col,
    output logic      [lcd_pkg::LCD_DATA_W-1:0] char_code
);
    import lcd_pkg::*;

    logic                  is_win;
    logic [LCD_DATA_W-1:0] digit;

    assign is_win = (winner == WIN_P1) || (winner == WIN_P2);
    assign digit  = (winner == WIN_P2) ? CHAR_TWO : CHAR_ONE;

    always_comb begin
        char_code = CHAR_SPACE;
        if (is_win && (32'(col) < LINE_CHARS)) begin
            if (!line_sel) begin
                case (col)  // " Px Win"
                    5'd1:    char_code = CHAR_P;
                    5'd2:    char_code = digit;
                    5'd4:    char_code = CHAR_W;
                    5'd5:    char_code = CHAR_I;
                    5'd6:    char_code = CHAR_N;
                    default: char_code = CHAR_SPACE;
                endcase
            end else begin
                case (col)  // Two groups of three hearts
                    5'd1, 5'd2, 5'd3: char_code = CHAR_HEART;
                    5'd5, 5'd6, 5'd7: char_code = CHAR_HEART;
                    default:          char_code = CHAR_SPACE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: lcd/lcd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer #(
    parameter int POWER_WAIT_CYCLES   = 70,
    parameter int REFRESH_WAIT_CYCLES = 400,
    parameter int LINE_CHARS          = 16
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  var  lcd_pkg::winner_e               winner,
    output logic                                item_req,
    output logic                                item_rs,
    output logic [lcd_pkg::LCD_DATA_W-1:0]      item_data,
    input  wire logic                           item_ack
);
    import lcd_pkg::*;

    localparam int WAIT_MAX = (POWER_WAIT_CYCLES > REFRESH_WAIT_CYCLES) ?
                              POWER_WAIT_CYCLES : REFRESH_WAIT_CYCLES;
    localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

    lcd_state_e            state;
    winner_e               win_q;
    logic [WAIT_W-1:0]     wait_cnt;
    logic [COL_W-1:0]      col;
    logic                  addr_done;  // Line address already sent
    logic [LCD_DATA_W-1:0] rom_char;

    lcd_message_rom #(
        .LINE_CHARS (LINE_CHARS)
    ) u_rom (
        .winner    (win_q),
        .line_sel  (state == ST_LINE2),
        .col       (col),
        .char_code (rom_char)
    );

    // Item for the current state, stable while item_req is high
    always_comb begin
        item_rs   = 1'b0;
        item_data = '0;
        case (state)
            ST_FUNCTION_SET: item_data = CMD_FUNCTION_SET;
            ST_ENTRY_MODE:   item_data = CMD_ENTRY_MODE;
            ST_DISPLAY_ON:   item_data = CMD_DISPLAY_ON;
            ST_LINE1, ST_LINE2: begin
                if (addr_done) begin
                    item_rs   = 1'b1;
                    item_data = rom_char;
                end else begin
                    item_data = (state == ST_LINE1) ? CMD_LINE1_ADDR : CMD_LINE2_ADDR;
                end
            end
            ST_RETURN_HOME:  item_data = CMD_RETURN_HOME;
            ST_CLEAR:        item_data = CMD_CLEAR;
            default:         item_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= ST_POWER_WAIT;
            win_q     <= WIN_NONE;
            wait_cnt  <= '0;
            col       <= '0;
            addr_done <= 1'b0;
            item_req  <= 1'b0;
        end else begin
            case (state)
                ST_POWER_WAIT: begin
                    if (wait_cnt == WAIT_W'(POWER_WAIT_CYCLES - 1)) begin
                        wait_cnt <= '0;
                        state    <= ST_FUNCTION_SET;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_REFRESH_WAIT: begin
                    if (wait_cnt == WAIT_W'(REFRESH_WAIT_CYCLES - 1)) begin
                        wait_cnt <= '0;
                        win_q    <= winner;  // One message per frame
                        state    <= ST_LINE1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    if (item_req) begin
                        if (item_ack) begin  // Item accepted
                            item_req <= 1'b0;
                            case (state)
                                ST_FUNCTION_SET: state <= ST_ENTRY_MODE;
                                ST_ENTRY_MODE:   state <= ST_DISPLAY_ON;
                                ST_DISPLAY_ON: begin
                                    win_q <= winner;
                                    state <= ST_LINE1;
                                end
                                ST_LINE1, ST_LINE2: begin
                                    if (!addr_done) begin
                                        addr_done <= 1'b1;
                                    end else if (col == COL_W'(LINE_CHARS - 1)) begin
                                        col       <= '0;
                                        addr_done <= 1'b0;
                                        state     <= (state == ST_LINE1) ?
                                                     ST_LINE2 : ST_RETURN_HOME;
                                    end else begin
                                        col <= col + 1'b1;
                                    end
                                end
                                ST_RETURN_HOME:  state <= ST_CLEAR;
                                default:         state <= ST_REFRESH_WAIT;
                            endcase
                        end
                    end else if (!item_ack) begin  // Previous ack released
                        item_req <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: lcd/lcd_item_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_item_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           item_req,
    input  wire logic                           item_rs,
    input  wire logic [lcd_pkg::LCD_DATA_W-1:0] item_data,
    output logic                                item_ack,
    output logic                                bus_req,
    output logic                                bus_rs,
    output logic      [lcd_pkg::LCD_DATA_W-1:0] bus_data,
    input  wire logic                           bus_ack
);
    import lcd_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [LCD_DATA_W:0] mem [FIFO_DEPTH];  // {rs, data}
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                bus_ack_q;
    logic                push;
    logic                pop;

    assign push = item_req && !item_ack && (count < CNT_W'(FIFO_DEPTH));
    assign pop  = bus_ack_q && !bus_ack;  // Falling ack ends the transfer

    assign {bus_rs, bus_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {item_rs, item_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            item_ack  <= 1'b0;
            bus_req   <= 1'b0;
            bus_ack_q <= 1'b0;
        end else begin
            bus_ack_q <= bus_ack;

            if (push) begin
                item_ack <= 1'b1;
                wr_ptr   <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (!item_req) begin
                item_ack <= 1'b0;
            end

            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (bus_req && bus_ack) begin
                bus_req <= 1'b0;
            end else if (!bus_req && !bus_ack && !bus_ack_q && (count != '0)) begin
                bus_req <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: lcd/lcd_bus_driver.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_driver #(
    parameter int E_HIGH_CYCLES = 4,
    parameter int E_LOW_CYCLES  = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           bus_req,
    input  wire logic                           bus_rs,
    input  wire logic [lcd_pkg::LCD_DATA_W-1:0] bus_data,
    output logic                                bus_ack,
    output logic                                lcd_e,
    output logic                                lcd_rs,
    output logic                                lcd_rw,
    output logic      [lcd_pkg::LCD_DATA_W-1:0] lcd_data
);
    localparam int PHASE_MAX = (E_HIGH_CYCLES > E_LOW_CYCLES) ? E_HIGH_CYCLES : E_LOW_CYCLES;
    localparam int PHASE_W   = $clog2(PHASE_MAX + 1);

    typedef enum logic [2:0] {
        DRV_IDLE,
        DRV_SETUP,
        DRV_E_HIGH,
        DRV_E_LOW,
        DRV_ACK
    } drv_state_e;

    drv_state_e         state;
    logic [PHASE_W-1:0] phase_cnt;

    assign lcd_rw = 1'b0;  // Write only

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= DRV_IDLE;
            phase_cnt <= '0;
            bus_ack   <= 1'b0;
            lcd_e     <= 1'b0;
            lcd_rs    <= 1'b0;
            lcd_data  <= '0;
        end else begin
            case (state)
                DRV_IDLE: begin
                    if (bus_req) begin
                        lcd_rs   <= bus_rs;
                        lcd_data <= bus_data;
                        state    <= DRV_SETUP;
                    end
                end
                DRV_SETUP: begin  // Address setup before E rises
                    lcd_e     <= 1'b1;
                    phase_cnt <= '0;
                    state     <= DRV_E_HIGH;
                end
                DRV_E_HIGH: begin
                    if (phase_cnt == PHASE_W'(E_HIGH_CYCLES - 1)) begin
                        lcd_e     <= 1'b0;
                        phase_cnt <= '0;
                        state     <= DRV_E_LOW;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                DRV_E_LOW: begin
                    if (phase_cnt == PHASE_W'(E_LOW_CYCLES - 1)) begin
                        bus_ack <= 1'b1;
                        state   <= DRV_ACK;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                default: begin
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= DRV_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/score_lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module score_lcd_top #(
    parameter int POWER_WAIT_CYCLES   = 70,
    parameter int REFRESH_WAIT_CYCLES = 400,
    parameter int LINE_CHARS          = 16,
    parameter int E_HIGH_CYCLES       = 4,
    parameter int E_LOW_CYCLES        = 4,
    parameter int FIFO_DEPTH          = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  var  lcd_pkg::winner_e               winner,
    output logic                                lcd_e,
    output logic                                lcd_rs,
    output logic                                lcd_rw,
    output logic      [lcd_pkg::LCD_DATA_W-1:0] lcd_data
);
    import lcd_pkg::*;

    logic                  item_req;
    logic                  item_rs;
    logic [LCD_DATA_W-1:0] item_data;
    logic                  item_ack;
    logic                  bus_req;
    logic                  bus_rs;
    logic [LCD_DATA_W-1:0] bus_data;
    logic                  bus_ack;

    lcd_sequencer #(
        .POWER_WAIT_CYCLES   (POWER_WAIT_CYCLES),
        .REFRESH_WAIT_CYCLES (REFRESH_WAIT_CYCLES),
        .LINE_CHARS          (LINE_CHARS)
    ) u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .winner    (winner),
        .item_req  (item_req),
        .item_rs   (item_rs),
        .item_data (item_data),
        .item_ack  (item_ack)
    );

    lcd_item_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .item_req  (item_req),
        .item_rs   (item_rs),
        .item_data (item_data),
        .item_ack  (item_ack),
        .bus_req   (bus_req),
        .bus_rs    (bus_rs),
        .bus_data  (bus_data),
        .bus_ack   (bus_ack)
    );

    lcd_bus_driver #(
        .E_HIGH_CYCLES (E_HIGH_CYCLES),
        .E_LOW_CYCLES  (E_LOW_CYCLES)
    ) u_driver (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_rs   (bus_rs),
        .bus_data (bus_data),
        .bus_ack  (bus_ack),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_score_lcd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_score_lcd;
    import lcd_pkg::*;

    localparam int POWER_WAIT_CYCLES   = 10;
    localparam int REFRESH_WAIT_CYCLES = 20;
    localparam int LINE_CHARS          = 12;
    localparam int E_HIGH_CYCLES       = 3;
    localparam int E_LOW_CYCLES        = 2;
    localparam int FIFO_DEPTH          = 4;
    localparam int FRAME_LEN           = 2 * LINE_CHARS + 4;
    localparam int WAIT_LIMIT          = 2000;  // Cycles, well over one frame

    logic       clk;
    logic       rst;
    winner_e    winner;
    logic       lcd_e;
    logic       lcd_rs;
    logic       lcd_rw;
    logic [7:0] lcd_data;

    logic [1:0] frame_win [$];  // Winner code per frame, in stimulus order
    logic [8:0] bus_prev;
    logic       e_prev;
    logic       pulse_seen;
    int         high_cnt;
    int         low_cnt;
    int         write_cnt;
    int         c0_count;
    int         frames_done;

    score_lcd_top #(
        .POWER_WAIT_CYCLES   (POWER_WAIT_CYCLES),
        .REFRESH_WAIT_CYCLES (REFRESH_WAIT_CYCLES),
        .LINE_CHARS          (LINE_CHARS),
        .E_HIGH_CYCLES       (E_HIGH_CYCLES),
        .E_LOW_CYCLES        (E_LOW_CYCLES),
        .FIFO_DEPTH          (FIFO_DEPTH)
    ) u_score_lcd_top (
        .clk      (clk),
        .rst      (rst),
        .winner   (winner),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                            test, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] message_char(input logic [1:0] win, input int line,
                                                input int col);
        string text;
        if (win != WIN_P1 && win != WIN_P2) return 8'h20;  // Blank, code 3 too
        text = (win == WIN_P1) ? " P1 Win" : " P2 Win";
        if (line == 0) return (col < text.len()) ? text[col] : 8'h20;
        return ((col >= 1 && col <= 3) || (col >= 5 && col <= 7)) ? 8'h9D : 8'h20;
    endfunction

    // Expected {rs, data} at position pos of a refresh frame
    function automatic logic [8:0] frame_item(input logic [1:0] win, input int pos);
        if (pos == 0) return {1'b0, 8'h80};
        if (pos <= LINE_CHARS) return {1'b1, message_char(win, 0, pos - 1)};
        if (pos == LINE_CHARS + 1) return {1'b0, 8'hC0};
        if (pos <= 2 * LINE_CHARS + 1) return {1'b1, message_char(win, 1, pos - LINE_CHARS - 2)};
        if (pos == 2 * LINE_CHARS + 2) return {1'b0, 8'h02};
        return {1'b0, 8'h01};
    endfunction

    task automatic check_write(input logic [8:0] got);
        logic [8:0] exp;
        int         frame;
        frame = (write_cnt - 3) / FRAME_LEN;
        if (write_cnt >= 3 && frame >= frame_win.size()) begin
            abort_run("A frame started before its winner value was applied");
        end else begin
            case (write_cnt)
                0:       exp = 9'h03C;  // Function set
                1:       exp = 9'h006;
                2:       exp = 9'h00C;
                default: exp = frame_item(frame_win[frame], (write_cnt - 3) % FRAME_LEN);
            endcase
            assert (got == exp) else report_mismatch("write_stream", exp, got);
            if (got == 9'h0C0) c0_count++;
            if (got == 9'h001) frames_done++;
            write_cnt++;
        end
    endtask

    // Bus monitor, sampled mid-cycle where the DUT outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            assert (lcd_rw == 1'b0) else report_mismatch("rw_low", 0, lcd_rw);
            if (lcd_e || e_prev) begin
                assert ({lcd_rs, lcd_data} == bus_prev)
                    else report_mismatch("bus_stable", bus_prev, {lcd_rs, lcd_data});
            end
            if (lcd_e && !e_prev) begin
                if (!pulse_seen) begin
                    assert (low_cnt >= POWER_WAIT_CYCLES)
                        else report_mismatch("power_wait", POWER_WAIT_CYCLES, low_cnt);
                end else begin
                    assert (low_cnt >= E_LOW_CYCLES)
                        else report_mismatch("e_low_time", E_LOW_CYCLES, low_cnt);
                end
                pulse_seen = 1'b1;
                high_cnt   = 1;
            end else if (lcd_e) begin
                high_cnt++;
            end
            if (!lcd_e && e_prev) begin  // One LCD write
                assert (high_cnt == E_HIGH_CYCLES)
                    else report_mismatch("e_high_time", E_HIGH_CYCLES, high_cnt);
                check_write({lcd_rs, lcd_data});
                low_cnt = 1;
            end else if (!lcd_e) begin
                low_cnt++;
            end
            e_prev   = lcd_e;
            bus_prev = {lcd_rs, lcd_data};
        end
    end

    task automatic wait_line2_addr(input int target);
        int cycles;
        cycles = 0;
        while (c0_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("Timeout waiting for a line-2 address write");
        end
    endtask

    task automatic wait_frames_done(input int target);
        int cycles;
        cycles = 0;
        while (frames_done < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("Timeout waiting for a frame to complete");
        end
    endtask

    initial begin
        logic [31:0] rng;
        logic [1:0]  code;
        logic [3:0]  seen;
        int          frame;
        rng         = xorshift32(32'h8ab8_426b);
        code        = rng[1:0];
        seen        = '0;
        seen[code]  = 1'b1;
        frame       = 0;
        rst         = 1'b0;
        winner      = winner_e'(code);
        bus_prev    = '0;
        e_prev      = 1'b0;
        pulse_seen  = 1'b0;
        high_cnt    = 0;
        low_cnt     = 0;
        write_cnt   = 0;
        c0_count    = 0;
        frames_done = 0;
        frame_win.push_back(code);

        repeat (4) @(posedge clk);
        @(negedge clk);
        assert ({lcd_e, lcd_rs, lcd_rw, lcd_data} == 11'd0)
            else report_mismatch("reset_outputs", 0, {lcd_e, lcd_rs, lcd_rw, lcd_data});
        rst = 1'b1;

        // New winner after each line-2 address, so the change lands mid-frame
        while (!(frame >= 4 && &seen)) begin
            if (frame >= 40) abort_run("Not all winner codes were reached in 40 frames");
            wait_line2_addr(frame + 1);
            rng    = xorshift32(rng);
            code   = code ^ (2'(rng % 3) + 2'd1);
            winner = winner_e'(code);
            frame_win.push_back(code);
            seen[code] = 1'b1;
            frame++;
        end
        wait_frames_done(frame_win.size());
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
common/lcd_pkg.sv
lcd/lcd_message_rom.sv
lcd/lcd_sequencer.sv
lcd/lcd_item_fifo.sv
lcd/lcd_bus_driver.sv
verilog/score_lcd_top.sv
tb/tb_score_lcd.sv
